/* compile.f */
+incdir+include
rtl/csr_pkg.sv
rtl/csr_req_decode.sv
rtl/csr_trap_regs.sv
rtl/csr_pmp_entry.sv
rtl/csr_read_mux.sv
rtl/csr_regfile_top.sv
testbench/tb_csr_regfile.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the output for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f compile.f \
	--top-module tb_csr_regfile -o tb_csr_regfile \
	&& ./obj_dir/tb_csr_regfile | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* testbench/tb_csr_regfile.sv */
`default_nettype none
`include "csr_macros.svh"

module tb_csr_regfile import csr_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [`CSR_XLEN-1:0] MstMask = 32'h0022_0888;  // MIE, MPIE, MPP, MPRV, TW
	localparam logic [`CSR_XLEN-1:0] IrqMask = 32'h0000_0888;  // MSI, MTI, MEI

	logic                 clk_i;
	logic                 rstn_i;
	csr_req_t             csr_req_i;
	csr_trap_t            trap_i;
	csr_irq_t             irq_i;
	logic [`CSR_XLEN-1:0] rdata_o;
	csr_ctrl_t            ctrl_o;
	pmp_entry_t           pmp_o [`CSR_PMP_ENTRIES];

	integer seed;                                  // $random state
	int     n_checks;
	int     n_errors;
	int     n_tests;
	int     test_errs;                             // Errors of the running test

	// Shadow registers at architectural bit positions
	logic [`CSR_XLEN-1:0] m_mst;
	logic [`CSR_XLEN-1:0] m_mie;
	logic [`CSR_XLEN-1:0] m_mip;
	logic [`CSR_XLEN-1:0] m_mepc;
	logic [`CSR_XLEN-1:0] m_mcause;
	logic [`CSR_XLEN-1:0] m_mtval;
	logic [`CSR_XLEN-1:0] m_mcfgptr;
	logic [`CSR_XLEN-1:0] m_paddr [`CSR_PMP_ENTRIES];
	logic [`CSR_XLEN-1:0] m_pcfg [`CSR_PMP_CFG_REGS];

	csr_regfile_top u_csr_regfile_top (
		.clk_i     (clk_i),
		.rstn_i    (rstn_i),
		.csr_req_i (csr_req_i),
		.trap_i    (trap_i),
		.irq_i     (irq_i),
		.rdata_o   (rdata_o),
		.ctrl_o    (ctrl_o),
		.pmp_o     (pmp_o)
	);

	initial clk_i = 1'b0;
	always #10 clk_i = ~clk_i;                     // 20 ns period

	initial begin : reset_proc
		rstn_i = 1'b0;
		repeat (5) @(posedge clk_i);
		#2 rstn_i = 1'b1;
	end

	task automatic check_rdata(input string name, input logic [`CSR_XLEN-1:0] exp_v,
		input logic [`CSR_XLEN-1:0] act_v);
		n_checks++;
		if (act_v !== exp_v) begin
			n_errors++;
			test_errs++;
			$display("Fail %s: expected %08h, actual %08h", name, exp_v, act_v);
		end
	endtask

	task automatic check_ctrl(input string name, input csr_ctrl_t exp_v, input csr_ctrl_t act_v);
		n_checks++;
		if (act_v !== exp_v) begin
			n_errors++;
			test_errs++;
			$display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
		end
	endtask

	task automatic check_pmp(input string name, input pmp_entry_t exp_v, input pmp_entry_t act_v);
		n_checks++;
		if (act_v !== exp_v) begin
			n_errors++;
			test_errs++;
			$display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
		end
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		$display("Test %s finished with %0d errors", name, test_errs);
		test_errs = 0;
	endtask

	// One request cycle with the write landing at the second edge
	task automatic drive_cycle(input csr_req_t req, input csr_trap_t trap);
		@(posedge clk_i);
		#2;
		csr_req_i = req;
		trap_i    = trap;
		@(posedge clk_i);
		#2;
		csr_req_i = '0;
		trap_i    = '0;
	endtask

	task automatic sw_write(input logic [`CSR_ADDR_W-1:0] addr, input logic set,
		input logic clr, input logic [`CSR_XLEN-1:0] data);
		csr_req_t req;
		req        = '0;
		req.en     = 1'b1;
		req.addr   = addr;
		req.wdata  = data;
		req.op.set = set;
		req.op.clr = clr;
		drive_cycle(req, '0);
	endtask

	// Combinational read sampled mid-cycle
	task automatic sample_csr(input logic [`CSR_ADDR_W-1:0] addr, input logic rd,
		output logic [`CSR_XLEN-1:0] data);
		csr_req_i       = '0;
		csr_req_i.en    = 1'b1;
		csr_req_i.addr  = addr;
		csr_req_i.op.rd = rd;
		#8;
		data      = rdata_o;
		csr_req_i = '0;
	endtask

	task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr, input logic rd,
		output logic [`CSR_XLEN-1:0] data);
		@(posedge clk_i);
		#2;
		sample_csr(addr, rd, data);
	endtask

	task automatic expect_csr(input string name, input logic [`CSR_ADDR_W-1:0] addr,
		input logic [`CSR_XLEN-1:0] exp_v);
		logic [`CSR_XLEN-1:0] act;
		read_csr(addr, 1'b1, act);
		check_rdata(name, exp_v, act);
	endtask

	function automatic csr_ctrl_t model_ctrl();
		csr_ctrl_t c;
		c          = '0;
		c.mie      = m_mst[`CSR_MSTATUS_MIE_BIT];
		c.mpie     = m_mst[`CSR_MSTATUS_MPIE_BIT];
		c.mpp      = m_mst[`CSR_MSTATUS_MPP_BIT];
		c.mprv     = m_mst[`CSR_MSTATUS_MPRV_BIT];
		c.tw       = m_mst[`CSR_MSTATUS_TW_BIT];
		c.mepc     = m_mepc;
		c.mcause   = m_mcause;
		c.mtval    = m_mtval;
		c.ext_int  = {m_mip[`CSR_IRQ_MEI_BIT], m_mie[`CSR_IRQ_MEI_BIT]};  // {pending, enable}
		c.tim_int  = {m_mip[`CSR_IRQ_MTI_BIT], m_mie[`CSR_IRQ_MTI_BIT]};
		c.soft_int = {m_mip[`CSR_IRQ_MSI_BIT], m_mie[`CSR_IRQ_MSI_BIT]};
		return c;
	endfunction

	function automatic pmp_entry_t model_pmp(input int i);
		pmp_entry_t e;
		e.addr = m_paddr[i];
		e.cfg  = pmp_cfg_t'(m_pcfg[i / `CSR_PMP_CFG_PER_WORD]
			[8 * (i % `CSR_PMP_CFG_PER_WORD) +: 8]);
		return e;
	endfunction

	// Write, set, then clear with fresh random data
	task automatic exercise_word(input string name, input logic [`CSR_ADDR_W-1:0] addr,
		inout logic [`CSR_XLEN-1:0] model);
		logic [`CSR_XLEN-1:0] d;
		d = $random(seed);
		sw_write(addr, 1'b1, 1'b1, d);
		model = d;
		expect_csr({name, " write"}, addr, model);
		d = $random(seed);
		sw_write(addr, 1'b1, 1'b0, d);
		model = model | d;
		expect_csr({name, " set"}, addr, model);
		d = $random(seed);
		sw_write(addr, 1'b0, 1'b1, d);
		model = model & ~d;
		expect_csr({name, " clear"}, addr, model);
	endtask

	task automatic test_reset_ids();
		logic [`CSR_XLEN-1:0] act;
		expect_csr("mvendorid", `CSR_A_MVENDORID, 32'h0);
		expect_csr("mhartid", `CSR_A_MHARTID, 32'h0);
		expect_csr("mstatush", `CSR_A_MSTATUSH, 32'h0);
		expect_csr("marchid", `CSR_A_MARCHID, `CSR_MARCHID_VAL);
		expect_csr("mimpid", `CSR_A_MIMPID, `CSR_MIMPID_VAL);
		expect_csr("misa", `CSR_A_MISA, `CSR_MISA_VAL);
		expect_csr("mtvec", `CSR_A_MTVEC, `CSR_MTVEC_VAL);
		expect_csr("mstatus reset", `CSR_A_MSTATUS, 32'h0);
		expect_csr("mie reset", `CSR_A_MIE, 32'h0);
		expect_csr("mip reset", `CSR_A_MIP, 32'h0);
		expect_csr("mepc reset", `CSR_A_MEPC, 32'h0);
		expect_csr("mcause reset", `CSR_A_MCAUSE, 32'h0);
		expect_csr("mtval reset", `CSR_A_MTVAL, 32'h0);
		expect_csr("mconfigptr reset", `CSR_A_MCONFIGPTR, 32'h0);
		expect_csr("unknown address", 12'h7C0, 32'h0);
		read_csr(`CSR_A_MARCHID, 1'b0, act);     // No rd bit
		check_rdata("read without rd", 32'h0, act);
		check_ctrl("ctrl after reset", '0, ctrl_o);
		for (int i = 0; i < `CSR_PMP_ENTRIES; i++) begin
			check_pmp($sformatf("pmp%0d after reset", i), '0, pmp_o[i]);
		end
		finish_test("reset_ids");
	endtask

	task automatic test_full_words();
		exercise_word("mepc", `CSR_A_MEPC, m_mepc);
		exercise_word("mtval", `CSR_A_MTVAL, m_mtval);
		exercise_word("mconfigptr", `CSR_A_MCONFIGPTR, m_mcfgptr);
		check_ctrl("ctrl mepc mtval", model_ctrl(), ctrl_o);
		finish_test("full_words");
	endtask

	task automatic test_field_mask();
		logic [`CSR_XLEN-1:0] d;
		sw_write(`CSR_A_MSTATUS, 1'b1, 1'b1, 32'hFFFF_FFFF);
		m_mst = MstMask;
		expect_csr("mstatus all ones", `CSR_A_MSTATUS, m_mst);
		sw_write(`CSR_A_MIE, 1'b1, 1'b1, 32'hFFFF_FFFF);
		m_mie = IrqMask;
		expect_csr("mie all ones", `CSR_A_MIE, m_mie);
		check_ctrl("ctrl fields set", model_ctrl(), ctrl_o);
		sw_write(`CSR_A_MSTATUS, 1'b0, 1'b1, 32'h0002_0008);  // MPRV and MIE off
		m_mst = m_mst & ~32'h0002_0008;
		expect_csr("mstatus clear", `CSR_A_MSTATUS, m_mst);
		sw_write(`CSR_A_MIE, 1'b0, 1'b1, 32'h0000_0080);
		m_mie = m_mie & ~32'h0000_0080;
		expect_csr("mie clear", `CSR_A_MIE, m_mie);
		sw_write(`CSR_A_MSTATUS, 1'b1, 1'b0, 32'hF000_0009);  // Undefined bits dropped
		m_mst = m_mst | (32'hF000_0009 & MstMask);
		expect_csr("mstatus set", `CSR_A_MSTATUS, m_mst);
		check_ctrl("ctrl after clears", model_ctrl(), ctrl_o);
		d = $random(seed);
		sw_write(`CSR_A_MCAUSE, 1'b1, 1'b1, d);  // mcause is not software writable
		expect_csr("mcause write ignored", `CSR_A_MCAUSE, m_mcause);
		finish_test("field_mask");
	endtask

	task automatic test_trap_priority();
		csr_req_t  req;
		csr_trap_t trap;
		trap        = '0;
		trap.we     = 1'b1;
		trap.mepc   = $random(seed);
		trap.mcause = $random(seed);
		trap.mtval  = $random(seed);
		trap.mie    = ~m_mst[`CSR_MSTATUS_MIE_BIT];
		trap.mpie   = ~m_mst[`CSR_MSTATUS_MPIE_BIT];
		trap.mpp    = ~m_mst[`CSR_MSTATUS_MPP_BIT];
		req         = '0;
		req.en      = 1'b1;
		req.addr    = `CSR_A_MEPC;
		req.wdata   = ~trap.mepc;                  // Conflicting software write
		req.op.set  = 1'b1;
		req.op.clr  = 1'b1;
		drive_cycle(req, trap);
		m_mepc   = trap.mepc;
		m_mcause = trap.mcause;
		m_mtval  = trap.mtval;
		m_mst[`CSR_MSTATUS_MIE_BIT]  = trap.mie;
		m_mst[`CSR_MSTATUS_MPIE_BIT] = trap.mpie;
		m_mst[`CSR_MSTATUS_MPP_BIT]  = trap.mpp;
		expect_csr("trap mepc", `CSR_A_MEPC, m_mepc);
		expect_csr("trap mcause", `CSR_A_MCAUSE, m_mcause);
		expect_csr("trap mtval", `CSR_A_MTVAL, m_mtval);
		expect_csr("trap mstatus", `CSR_A_MSTATUS, m_mst);
		check_ctrl("ctrl after trap", model_ctrl(), ctrl_o);
		finish_test("trap_priority");
	endtask

	task automatic test_irq();
		logic [`CSR_XLEN-1:0] act;
		for (int p = 0; p < 8; p++) begin
			@(posedge clk_i);
			#2;
			irq_i = csr_irq_t'(p[2:0]);              // {sw, tim, ext}
			m_mip = '0;
			m_mip[`CSR_IRQ_MSI_BIT] = p[2];
			m_mip[`CSR_IRQ_MTI_BIT] = p[1];
			m_mip[`CSR_IRQ_MEI_BIT] = p[0];
			expect_csr($sformatf("mip pattern %0d", p), `CSR_A_MIP, m_mip);  // One edge later
			check_ctrl($sformatf("ctrl irq pattern %0d", p), model_ctrl(), ctrl_o);
		end
		sw_write(`CSR_A_MIP, 1'b1, 1'b1, 32'h0);
		sample_csr(`CSR_A_MIP, 1'b1, act);       // Same cycle as the write edge
		check_rdata("mip write ignored", m_mip, act);
		finish_test("irq");
	endtask

	task automatic test_pmp();
		for (int i = 0; i < `CSR_PMP_ENTRIES; i++) begin
			exercise_word($sformatf("pmpaddr%0d", i), `CSR_ADDR_W'(`CSR_A_PMPADDR0 + i),
				m_paddr[i]);
		end
		for (int j = 0; j < `CSR_PMP_CFG_REGS; j++) begin
			exercise_word($sformatf("pmpcfg%0d", j), `CSR_ADDR_W'(`CSR_A_PMPCFG0 + j),
				m_pcfg[j]);
		end
		for (int i = 0; i < `CSR_PMP_ENTRIES; i++) begin
			expect_csr($sformatf("pmpaddr%0d readback", i),
				`CSR_ADDR_W'(`CSR_A_PMPADDR0 + i), m_paddr[i]);
			check_pmp($sformatf("pmp_o[%0d]", i), model_pmp(i), pmp_o[i]);
		end
		finish_test("pmp");
	endtask

	initial begin : main_proc
		int wait_cnt;
		seed      = 13774;
		n_checks  = 0;
		n_errors  = 0;
		n_tests   = 0;
		test_errs = 0;
		csr_req_i = '0;
		trap_i    = '0;
		irq_i     = '0;
		m_mst     = '0;
		m_mie     = '0;
		m_mip     = '0;
		m_mepc    = '0;
		m_mcause  = '0;
		m_mtval   = '0;
		m_mcfgptr = '0;
		for (int i = 0; i < `CSR_PMP_ENTRIES; i++) begin
			m_paddr[i] = '0;
		end
		for (int j = 0; j < `CSR_PMP_CFG_REGS; j++) begin
			m_pcfg[j] = '0;
		end
		wait_cnt = 0;
		while (rstn_i !== 1'b1 && wait_cnt < 20) begin
			@(posedge clk_i);
			wait_cnt++;
		end
		if (rstn_i !== 1'b1) begin
			$display("Timeout: reset was never released");
			$display("Something failed");
		end else begin
			test_reset_ids();
			test_full_words();
			test_field_mask();
			test_trap_priority();
			test_irq();
			test_pmp();
			$display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
			if (n_errors == 0) begin
				$display("Everything OK");
			end else begin
				$display("Something failed");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/csr_regfile_top.sv */
`default_nettype none
`include "csr_macros.svh"

module csr_regfile_top import csr_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rstn_i,
	input  csr_req_t             csr_req_i,        // CSR instruction request
	input  csr_trap_t            trap_i,           // Trap unit update
	input  csr_irq_t             irq_i,            // Interrupt pending lines
	output logic [`CSR_XLEN-1:0] rdata_o,          // Combinational read data
	output csr_ctrl_t            ctrl_o,
	output pmp_entry_t           pmp_o [`CSR_PMP_ENTRIES]
);

	csr_wcmd_t      wcmd;
	csr_trap_view_t trap_view;
	pmpcfg_word_u   cfg_wdata;                     // wdata seen as per-entry bytes

	assign cfg_wdata.raw = wcmd.wdata;

	csr_req_decode u_csr_req_decode (
		.csr_req_i (csr_req_i),
		.wcmd_o    (wcmd)
	);

	csr_trap_regs u_csr_trap_regs (
		.clk_i  (clk_i),
		.rstn_i (rstn_i),
		.wcmd_i (wcmd),
		.trap_i (trap_i),
		.irq_i  (irq_i),
		.view_o (trap_view),
		.ctrl_o (ctrl_o)
	);

	for (genvar i = 0; i < `CSR_PMP_ENTRIES; i++) begin : g_pmp
		csr_pmp_entry u_csr_pmp_entry (
			.clk_i       (clk_i),
			.rstn_i      (rstn_i),
			.kind_i      (wcmd.kind),
			.addr_we_i   (wcmd.pmpaddr_we[i]),
			.cfg_we_i    (wcmd.pmpcfg_we[i / `CSR_PMP_CFG_PER_WORD]),  // Owning word
			.wdata_i     (wcmd.wdata),
			.cfg_wdata_i (cfg_wdata.cfg[i % `CSR_PMP_CFG_PER_WORD]),  // Byte i mod 4
			.entry_o     (pmp_o[i])
		);
	end

	csr_read_mux u_csr_read_mux (
		.csr_req_i (csr_req_i),
		.view_i    (trap_view),
		.pmp_i     (pmp_o),
		.rdata_o   (rdata_o)
	);

endmodule

`default_nettype wire

/* rtl/csr_read_mux.sv */
`default_nettype none
`include "csr_macros.svh"

module csr_read_mux import csr_pkg::*; (
	input  csr_req_t             csr_req_i,        // Address and rd bit
	input  csr_trap_view_t       view_i,           // Trap block state
	input  pmp_entry_t           pmp_i [`CSR_PMP_ENTRIES],
	output logic [`CSR_XLEN-1:0] rdata_o
);

	pmpcfg_word_u cfg_word [`CSR_PMP_CFG_REGS];    // Entry bytes regrouped per word

	always_comb begin : cfg_pack_proc
		for (int j = 0; j < `CSR_PMP_CFG_REGS; j++) begin
			for (int k = 0; k < `CSR_PMP_CFG_PER_WORD; k++) begin
				cfg_word[j].cfg[k] = pmp_i[j * `CSR_PMP_CFG_PER_WORD + k].cfg;
			end
		end
	end

	always_comb begin : read_proc
		rdata_o = '0;                              // Unknown or no rd reads zero
		if (csr_req_i.en & csr_req_i.op.rd) begin
			case (csr_req_i.addr)
				`CSR_A_MVENDORID:  rdata_o = `CSR_MVENDORID_VAL;
				`CSR_A_MARCHID:    rdata_o = `CSR_MARCHID_VAL;
				`CSR_A_MIMPID:     rdata_o = `CSR_MIMPID_VAL;
				`CSR_A_MHARTID:    rdata_o = `CSR_MHARTID_VAL;
				`CSR_A_MISA:       rdata_o = `CSR_MISA_VAL;
				`CSR_A_MTVEC:      rdata_o = `CSR_MTVEC_VAL;   // Fixed vector base
				`CSR_A_MSTATUSH:   rdata_o = '0;               // No endianness bits
				`CSR_A_MCONFIGPTR: rdata_o = view_i.mconfigptr;
				`CSR_A_MEPC:       rdata_o = view_i.mepc;
				`CSR_A_MCAUSE:     rdata_o = view_i.mcause;
				`CSR_A_MTVAL:      rdata_o = view_i.mtval;
				`CSR_A_MSTATUS: begin
					rdata_o[`CSR_MSTATUS_MIE_BIT]  = view_i.st_mie;
					rdata_o[`CSR_MSTATUS_MPIE_BIT] = view_i.st_mpie;
					rdata_o[`CSR_MSTATUS_MPP_BIT]  = view_i.st_mpp;
					rdata_o[`CSR_MSTATUS_MPRV_BIT] = view_i.st_mprv;
					rdata_o[`CSR_MSTATUS_TW_BIT]   = view_i.st_tw;
				end
				`CSR_A_MIE: begin
					rdata_o[`CSR_IRQ_MSI_BIT] = view_i.mie.sw;
					rdata_o[`CSR_IRQ_MTI_BIT] = view_i.mie.tim;
					rdata_o[`CSR_IRQ_MEI_BIT] = view_i.mie.ext;
				end
				`CSR_A_MIP: begin
					rdata_o[`CSR_IRQ_MSI_BIT] = view_i.mip.sw;
					rdata_o[`CSR_IRQ_MTI_BIT] = view_i.mip.tim;
					rdata_o[`CSR_IRQ_MEI_BIT] = view_i.mip.ext;
				end
				default: begin
				end
			endcase
			// PMP ranges lie outside every fixed address above
			for (int j = 0; j < `CSR_PMP_CFG_REGS; j++) begin
				if (csr_req_i.addr == (`CSR_A_PMPCFG0 + `CSR_ADDR_W'(j))) begin
					rdata_o = cfg_word[j].raw;
				end
			end
			for (int i = 0; i < `CSR_PMP_ENTRIES; i++) begin
				if (csr_req_i.addr == (`CSR_A_PMPADDR0 + `CSR_ADDR_W'(i))) begin
					rdata_o = pmp_i[i].addr;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/csr_pmp_entry.sv */
`default_nettype none
`include "csr_macros.svh"

module csr_pmp_entry import csr_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rstn_i,
	input  csr_wkind_e           kind_i,           // Write, set or clear
	input  logic                 addr_we_i,        // pmpaddr strobe
	input  logic                 cfg_we_i,         // Strobe of the owning cfg word
	input  logic [`CSR_XLEN-1:0] wdata_i,
	input  pmp_cfg_t             cfg_wdata_i,      // This entry's byte of wdata
	output pmp_entry_t           entry_o
);

	localparam int PadW = `CSR_XLEN - `CSR_PMP_CFG_W;

	pmp_entry_t           entry_q;
	logic [`CSR_XLEN-1:0] cfg_next;                // Byte widened to word

	always_comb begin : cfg_next_proc
		cfg_next = csr_apply(kind_i, {{PadW{1'b0}}, entry_q.cfg},
			{{PadW{1'b0}}, cfg_wdata_i});
	end

	always_ff @(posedge clk_i) begin : entry_proc
		if (!rstn_i) begin
			entry_q <= '0;
		end else begin
			if (addr_we_i) begin
				entry_q.addr <= csr_apply(kind_i, entry_q.addr, wdata_i);
			end
			if (cfg_we_i) begin
				entry_q.cfg <= cfg_next[`CSR_PMP_CFG_W-1:0]; // Low byte only
			end
		end
	end

	assign entry_o = entry_q;

endmodule

`default_nettype wire

/* rtl/csr_trap_regs.sv */
`default_nettype none
`include "csr_macros.svh"

module csr_trap_regs import csr_pkg::*; (
	input  logic           clk_i,
	input  logic           rstn_i,
	input  csr_wcmd_t      wcmd_i,                 // Decoded software write
	input  csr_trap_t      trap_i,                 // Trap unit update
	input  csr_irq_t       irq_i,                  // Raw pending lines
	output csr_trap_view_t view_o,                 // Stored state for reads
	output csr_ctrl_t      ctrl_o                  // Datapath control
);

	csr_trap_view_t       view_q;
	logic [`CSR_XLEN-1:0] mst_old;                 // mstatus at architectural positions
	logic [`CSR_XLEN-1:0] mst_new;
	logic [`CSR_XLEN-1:0] mie_old;                 // mie at architectural positions
	logic [`CSR_XLEN-1:0] mie_new;

	// Only defined fields are picked back out, the rest is masked
	always_comb begin : next_proc
		mst_old = '0;
		mst_old[`CSR_MSTATUS_MIE_BIT]  = view_q.st_mie;
		mst_old[`CSR_MSTATUS_MPIE_BIT] = view_q.st_mpie;
		mst_old[`CSR_MSTATUS_MPP_BIT]  = view_q.st_mpp;
		mst_old[`CSR_MSTATUS_MPRV_BIT] = view_q.st_mprv;
		mst_old[`CSR_MSTATUS_TW_BIT]   = view_q.st_tw;
		mst_new = csr_apply(wcmd_i.kind, mst_old, wcmd_i.wdata);

		mie_old = '0;
		mie_old[`CSR_IRQ_MSI_BIT] = view_q.mie.sw;
		mie_old[`CSR_IRQ_MTI_BIT] = view_q.mie.tim;
		mie_old[`CSR_IRQ_MEI_BIT] = view_q.mie.ext;
		mie_new = csr_apply(wcmd_i.kind, mie_old, wcmd_i.wdata);
	end

	always_ff @(posedge clk_i) begin : regs_proc
		if (!rstn_i) begin
			view_q <= '0;
		end else begin
			view_q.mip <= irq_i;                       // Pending lines, one cycle lag
			if (trap_i.we) begin                       // Trap wins over software
				view_q.mepc    <= trap_i.mepc;
				view_q.mcause  <= trap_i.mcause;
				view_q.mtval   <= trap_i.mtval;
				view_q.st_mie  <= trap_i.mie;
				view_q.st_mpie <= trap_i.mpie;
				view_q.st_mpp  <= trap_i.mpp;
			end else begin
				if (wcmd_i.mstatus_we) begin
					view_q.st_mie  <= mst_new[`CSR_MSTATUS_MIE_BIT];
					view_q.st_mpie <= mst_new[`CSR_MSTATUS_MPIE_BIT];
					view_q.st_mpp  <= mst_new[`CSR_MSTATUS_MPP_BIT];
					view_q.st_mprv <= mst_new[`CSR_MSTATUS_MPRV_BIT];
					view_q.st_tw   <= mst_new[`CSR_MSTATUS_TW_BIT];
				end
				if (wcmd_i.mie_we) begin
					view_q.mie.sw  <= mie_new[`CSR_IRQ_MSI_BIT];
					view_q.mie.tim <= mie_new[`CSR_IRQ_MTI_BIT];
					view_q.mie.ext <= mie_new[`CSR_IRQ_MEI_BIT];
				end
				if (wcmd_i.mepc_we) begin
					view_q.mepc <= csr_apply(wcmd_i.kind, view_q.mepc, wcmd_i.wdata);
				end
				if (wcmd_i.mtval_we) begin
					view_q.mtval <= csr_apply(wcmd_i.kind, view_q.mtval, wcmd_i.wdata);
				end
				if (wcmd_i.mconfigptr_we) begin
					view_q.mconfigptr <= csr_apply(wcmd_i.kind, view_q.mconfigptr,
						wcmd_i.wdata);
				end
			end
		end
	end

	assign view_o = view_q;

	assign ctrl_o.mie      = view_q.st_mie;
	assign ctrl_o.mpie     = view_q.st_mpie;
	assign ctrl_o.mprv     = view_q.st_mprv;
	assign ctrl_o.mpp      = view_q.st_mpp;
	assign ctrl_o.tw       = view_q.st_tw;
	assign ctrl_o.mepc     = view_q.mepc;        // Return address for mret
	assign ctrl_o.mcause   = view_q.mcause;
	assign ctrl_o.mtval    = view_q.mtval;
	assign ctrl_o.ext_int  = {view_q.mip.ext, view_q.mie.ext};
	assign ctrl_o.tim_int  = {view_q.mip.tim, view_q.mie.tim};
	assign ctrl_o.soft_int = {view_q.mip.sw, view_q.mie.sw};

endmodule

`default_nettype wire

/* rtl/csr_req_decode.sv */
`default_nettype none
`include "csr_macros.svh"

module csr_req_decode import csr_pkg::*; (
	input  csr_req_t  csr_req_i,                   // CSR instruction request
	output csr_wcmd_t wcmd_o                       // Write kind and strobes
);

	logic       wr_act;                            // Request modifies a register
	csr_wkind_e kind;

	always_comb begin : kind_proc
		wr_act = csr_req_i.en & (csr_req_i.op.set | csr_req_i.op.clr);
		if (!wr_act) begin
			kind = WK_NONE;
		end else if (csr_req_i.op.set & csr_req_i.op.clr) begin
			kind = WK_WRITE;                           // Both bits give a full write
		end else if (csr_req_i.op.set) begin
			kind = WK_SET;
		end else begin
			kind = WK_CLEAR;
		end
	end

	always_comb begin : strobe_proc
		wcmd_o       = '0;
		wcmd_o.kind  = kind;
		wcmd_o.wdata = csr_req_i.wdata;
		if (wr_act) begin
			case (csr_req_i.addr)
				`CSR_A_MSTATUS:    wcmd_o.mstatus_we    = 1'b1;
				`CSR_A_MIE:        wcmd_o.mie_we        = 1'b1;
				`CSR_A_MEPC:       wcmd_o.mepc_we       = 1'b1;
				`CSR_A_MTVAL:      wcmd_o.mtval_we      = 1'b1;
				`CSR_A_MCONFIGPTR: wcmd_o.mconfigptr_we = 1'b1;
				default: begin
				end                                    // mcause, mip and RO ids
			endcase
			for (int i = 0; i < `CSR_PMP_ENTRIES; i++) begin
				if (csr_req_i.addr == (`CSR_A_PMPADDR0 + `CSR_ADDR_W'(i))) begin
					wcmd_o.pmpaddr_we[i] = 1'b1;           // 0x3B0 + i
				end
			end
			for (int j = 0; j < `CSR_PMP_CFG_REGS; j++) begin
				if (csr_req_i.addr == (`CSR_A_PMPCFG0 + `CSR_ADDR_W'(j))) begin
					wcmd_o.pmpcfg_we[j] = 1'b1;            // 0x3A0 + j
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/csr_pkg.sv */
`default_nettype none
`include "csr_macros.svh"

package csr_pkg;

	typedef struct packed {
		logic rd;                                  // Read back requested
		logic clr;                                 // Both clr and set mean full write
		logic set;
	} csr_op_t;

	typedef struct packed {
		logic                   en;                // Request valid this cycle
		logic [`CSR_ADDR_W-1:0] addr;
		logic [`CSR_XLEN-1:0]   wdata;
		csr_op_t                op;
	} csr_req_t;

	typedef enum logic [1:0] {
		WK_NONE,
		WK_WRITE,
		WK_SET,
		WK_CLEAR
	} csr_wkind_e;

	typedef struct packed {
		csr_wkind_e                    kind;
		logic [`CSR_XLEN-1:0]          wdata;
		logic                          mstatus_we;
		logic                          mie_we;
		logic                          mepc_we;
		logic                          mtval_we;
		logic                          mconfigptr_we;
		logic [`CSR_PMP_ENTRIES-1:0]   pmpaddr_we;  // One per entry
		logic [`CSR_PMP_CFG_REGS-1:0]  pmpcfg_we;   // One per cfg word
	} csr_wcmd_t;

	typedef struct packed {
		logic                 we;                  // Trap unit owns the registers this cycle
		logic [`CSR_XLEN-1:0] mepc;
		logic [`CSR_XLEN-1:0] mcause;
		logic [`CSR_XLEN-1:0] mtval;
		logic                 mie;                 // New mstatus fields
		logic                 mpie;
		logic                 mpp;
	} csr_trap_t;

	typedef struct packed {
		logic sw;
		logic tim;
		logic ext;
	} csr_irq_t;

	typedef struct packed {
		logic                 st_mie;              // mstatus fields
		logic                 st_mpie;
		logic                 st_mpp;
		logic                 st_mprv;
		logic                 st_tw;
		csr_irq_t             mie;                 // Interrupt enables
		csr_irq_t             mip;                 // Sampled pending lines
		logic [`CSR_XLEN-1:0] mepc;
		logic [`CSR_XLEN-1:0] mcause;
		logic [`CSR_XLEN-1:0] mtval;
		logic [`CSR_XLEN-1:0] mconfigptr;
	} csr_trap_view_t;

	typedef struct packed {
		logic                 mie;
		logic                 mpie;
		logic                 mprv;
		logic                 mpp;
		logic                 tw;
		logic [`CSR_XLEN-1:0] mepc;
		logic [`CSR_XLEN-1:0] mcause;
		logic [`CSR_XLEN-1:0] mtval;
		logic [1:0]           ext_int;             // {pending, enable}
		logic [1:0]           tim_int;
		logic [1:0]           soft_int;
	} csr_ctrl_t;

	typedef struct packed {
		logic       l;                             // Lock
		logic [1:0] rsvd;
		logic [1:0] a;                             // Address matching mode
		logic       x;
		logic       w;
		logic       r;
	} pmp_cfg_t;

	// A pmpcfg word is written whole but owned byte-wise by the entries
	typedef union packed {
		logic [`CSR_XLEN-1:0]                      raw;
		pmp_cfg_t [`CSR_PMP_CFG_PER_WORD-1:0]      cfg;  // cfg[0] in bits 7:0
	} pmpcfg_word_u;

	typedef struct packed {
		pmp_cfg_t             cfg;
		logic [`CSR_XLEN-1:0] addr;
	} pmp_entry_t;

	// Write, set or clear one register image
	function automatic logic [`CSR_XLEN-1:0] csr_apply(
		input csr_wkind_e           kind,
		input logic [`CSR_XLEN-1:0] old_v,
		input logic [`CSR_XLEN-1:0] wdata_v
	);
		logic [`CSR_XLEN-1:0] res;
		case (kind)
			WK_WRITE: res = wdata_v;
			WK_SET:   res = old_v | wdata_v;
			WK_CLEAR: res = old_v & ~wdata_v;
			default:  res = old_v;                 // Hold
		endcase
		return res;
	endfunction

endpackage

`default_nettype wire

/* include/csr_macros.svh */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN              32                  // Data width
`define CSR_ADDR_W            12                  // CSR address field width
`define CSR_PMP_ENTRIES       8                   // Number of PMP regions
`define CSR_PMP_CFG_W         8                   // One config byte per region
`define CSR_PMP_CFG_PER_WORD  (`CSR_XLEN / `CSR_PMP_CFG_W)
`define CSR_PMP_CFG_REGS      (`CSR_PMP_ENTRIES / `CSR_PMP_CFG_PER_WORD)

// Machine-mode CSR addresses
`define CSR_A_MSTATUS     12'h300
`define CSR_A_MISA        12'h301
`define CSR_A_MIE         12'h304
`define CSR_A_MTVEC       12'h305
`define CSR_A_MSTATUSH    12'h310
`define CSR_A_MEPC        12'h341
`define CSR_A_MCAUSE      12'h342
`define CSR_A_MTVAL       12'h343
`define CSR_A_MIP         12'h344
`define CSR_A_PMPCFG0     12'h3A0                 // pmpcfg words follow in order
`define CSR_A_PMPADDR0    12'h3B0                 // pmpaddr registers follow in order
`define CSR_A_MVENDORID   12'hF11
`define CSR_A_MARCHID     12'hF12
`define CSR_A_MIMPID      12'hF13
`define CSR_A_MHARTID     12'hF14
`define CSR_A_MCONFIGPTR  12'hF15

// Architectural bit positions
`define CSR_MSTATUS_MIE_BIT   3
`define CSR_MSTATUS_MPIE_BIT  7
`define CSR_MSTATUS_MPP_BIT   11                  // Low MPP bit only, M/U split
`define CSR_MSTATUS_MPRV_BIT  17
`define CSR_MSTATUS_TW_BIT    21
`define CSR_IRQ_MSI_BIT       3                   // Shared by mie and mip
`define CSR_IRQ_MTI_BIT       7
`define CSR_IRQ_MEI_BIT       11

// Fixed identification values
`define CSR_MVENDORID_VAL  32'h00000000           // Non-commercial
`define CSR_MARCHID_VAL    32'h7FFFFFFF
`define CSR_MIMPID_VAL     32'h00000001
`define CSR_MHARTID_VAL    32'h00000000           // Single hart
`define CSR_MISA_VAL       32'h40100100           // RV32, I and U
`define CSR_MTVEC_VAL      32'h00000101           // Base 0x100, vectored

`endif
